/* Bender.yml */
package:
  name: memorySubsystem

sources:
  - hw/memBusPkg.sv
  - hw/memoryInterface.sv
  - hw/arbiterInterface.sv
  - hw/roundRobinArbiter.sv
  - hw/memoryBus.sv
  - hw/sharedRam.sv
  - hw/memorySubsystem.sv
  - target: simulation
    files:
      - bench/memorySubsystemTb.sv

/* bench/memorySubsystemTb.sv */
`timescale 1ns/1ps

module memorySubsystemTb;

	localparam int accessTimeout = 200; // Cycles a device waits for its completion.
	localparam int randomAccesses = 200;

	logic clk;
	logic rst;
	memBusPkg::memAddress deviceAddress [memBusPkg::deviceCount];
	memBusPkg::memData deviceDataOut [memBusPkg::deviceCount];
	memBusPkg::deviceMask deviceReadEnabled;
	memBusPkg::deviceMask deviceWriteEnabled;
	memBusPkg::memData deviceDataIn [memBusPkg::deviceCount];
	memBusPkg::deviceMask deviceFunctionComplete;

	memBusPkg::memData refMemory [memBusPkg::ramDepth]; // Expected RAM contents.
	memBusPkg::deviceMask completions [$];
	int errorCount;
	int checkCount;

	memorySubsystem dut (
		.clk(clk),
		.rst(rst),
		.deviceAddress(deviceAddress),
		.deviceDataOut(deviceDataOut),
		.deviceReadEnabled(deviceReadEnabled),
		.deviceWriteEnabled(deviceWriteEnabled),
		.deviceDataIn(deviceDataIn),
		.deviceFunctionComplete(deviceFunctionComplete)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic checkData(input string name, input memBusPkg::memData expected,
		input memBusPkg::memData actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkMask(input string name, input memBusPkg::deviceMask expected,
		input memBusPkg::deviceMask actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAIL at %0t: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic checkLatency(input string name, input int expected, input int actual);
		checkCount++;
		if (actual != expected) begin
			errorCount++;
			$display("FAIL at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	function automatic memBusPkg::memData fillPattern(input memBusPkg::memAddress address);
		return memBusPkg::memData'({address, ~address});
	endfunction

	// Only the completing device may see the pulse or any read data.
	task automatic checkOthersIdle(input int device);
		checkMask("deviceFunctionComplete", memBusPkg::deviceMask'(1) << device,
			deviceFunctionComplete);
		for (int j = 0; j < memBusPkg::deviceCount; j++) begin
			if (j != device) begin
				checkData($sformatf("deviceDataIn[%0d]", j), '0, deviceDataIn[j]);
			end
		end
	endtask

	// Called and returns 2 ns after a rising edge.
	task automatic issueAccess(input int device, input bit isWrite,
		input memBusPkg::memAddress address, input memBusPkg::memData data,
		output memBusPkg::memData readValue, output int latency);
		int cycles;
		bit done;

		cycles = 0;
		done = 1'b0;
		readValue = '0;
		deviceAddress[device] = address;
		deviceDataOut[device] = data;
		if (isWrite) begin
			deviceWriteEnabled[device] = 1'b1;
		end else begin
			deviceReadEnabled[device] = 1'b1;
		end
		while (!done && cycles < accessTimeout) begin
			@(posedge clk);
			#1;
			cycles++;
			done = deviceFunctionComplete[device];
		end
		latency = cycles;
		if (!done) begin
			errorCount++;
			$display("Timeout at %0t: device %0d got no completion within %0d cycles",
				$time, device, accessTimeout);
		end else begin
			readValue = deviceDataIn[device];
			completions.push_back(deviceFunctionComplete);
			checkOthersIdle(device);
			if (isWrite) begin
				refMemory[address] = data;
			end else begin
				checkData($sformatf("deviceDataIn[%0d]", device), refMemory[address], readValue);
			end
		end
		#1;
		deviceReadEnabled[device] = 1'b0;
		deviceWriteEnabled[device] = 1'b0;
		// The request stays up through the completion cycle and the grant clears one edge later.
		repeat (2) @(posedge clk);
		#2;
	endtask

	task automatic applyReset();
		rst = 1'b1;
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
	endtask

	task automatic checkResetState();
		@(posedge clk);
		#1;
		checkMask("deviceFunctionComplete", '0, deviceFunctionComplete);
		for (int j = 0; j < memBusPkg::deviceCount; j++) begin
			checkData($sformatf("deviceDataIn[%0d]", j), '0, deviceDataIn[j]);
		end
		#1;
	endtask

	task automatic checkRoundRobin();
		memBusPkg::memData values [memBusPkg::deviceCount + 1];
		int latencies [memBusPkg::deviceCount + 1];
		int expectedOrder [5];

		expectedOrder = '{0, 1, 2, 3, 0};
		completions.delete();
		fork
			begin
				issueAccess(0, 1'b1, 8'h10, 16'h1000, values[0], latencies[0]);
				issueAccess(0, 1'b1, 8'h14, 16'h1400, values[4], latencies[4]);
			end
			issueAccess(1, 1'b1, 8'h11, 16'h1100, values[1], latencies[1]);
			issueAccess(2, 1'b1, 8'h12, 16'h1200, values[2], latencies[2]);
			issueAccess(3, 1'b1, 8'h13, 16'h1300, values[3], latencies[3]);
		join
		if (completions.size() != 5) begin
			errorCount++;
			$display("Round robin saw %0d completions instead of 5", completions.size());
		end else begin
			for (int n = 0; n < 5; n++) begin
				checkMask($sformatf("completion %0d", n),
					memBusPkg::deviceMask'(1) << expectedOrder[n], completions[n]);
			end
		end
	endtask

	task automatic fillMemory();
		memBusPkg::memData value;
		int latency;

		for (int a = 0; a < memBusPkg::ramDepth; a++) begin
			issueAccess(a % memBusPkg::deviceCount, 1'b1, memBusPkg::memAddress'(a),
				fillPattern(memBusPkg::memAddress'(a)), value, latency);
		end
	endtask

	task automatic checkSingleAccess();
		memBusPkg::memData value;
		int latency;

		issueAccess(0, 1'b1, 8'h5a, 16'hc3a5, value, latency);
		checkLatency("device 0 write latency", 1 + memBusPkg::ramLatency, latency);
		issueAccess(0, 1'b0, 8'h5a, '0, value, latency);
		checkLatency("device 0 read latency", 1 + memBusPkg::ramLatency, latency);
		checkData("deviceDataIn[0]", 16'hc3a5, value);
	endtask

	// Device 3 waits with its read held while device 1 completes.
	task automatic checkReadIsolation();
		memBusPkg::memData values [memBusPkg::deviceCount];
		int latencies [memBusPkg::deviceCount];

		fork
			issueAccess(1, 1'b0, 8'h21, '0, values[1], latencies[1]);
			issueAccess(3, 1'b0, 8'h63, '0, values[3], latencies[3]);
		join
		issueAccess(2, 1'b0, 8'h42, '0, values[2], latencies[2]);
	endtask

	task automatic runRandomTraffic();
		memBusPkg::deviceMask active;
		bit isWrite [memBusPkg::deviceCount];
		memBusPkg::memAddress addresses [memBusPkg::deviceCount];
		memBusPkg::memData data [memBusPkg::deviceCount];
		memBusPkg::memData values [memBusPkg::deviceCount];
		int latencies [memBusPkg::deviceCount];
		int issued;

		issued = 0;
		while (issued < randomAccesses) begin
			active = '0;
			for (int d = 0; d < memBusPkg::deviceCount; d++) begin
				if (issued < randomAccesses && $urandom_range(1, 0) == 1) begin
					active[d] = 1'b1;
					issued++;
				end
				isWrite[d] = $urandom_range(1, 0);
				addresses[d] = memBusPkg::memAddress'($urandom);
				data[d] = memBusPkg::memData'($urandom);
			end
			if (active == '0) begin
				active[$urandom_range(memBusPkg::deviceCount - 1, 0)] = 1'b1;
				issued++;
			end
			fork
				if (active[0]) begin
					issueAccess(0, isWrite[0], addresses[0], data[0], values[0], latencies[0]);
				end
				if (active[1]) begin
					issueAccess(1, isWrite[1], addresses[1], data[1], values[1], latencies[1]);
				end
				if (active[2]) begin
					issueAccess(2, isWrite[2], addresses[2], data[2], values[2], latencies[2]);
				end
				if (active[3]) begin
					issueAccess(3, isWrite[3], addresses[3], data[3], values[3], latencies[3]);
				end
			join
		end
	endtask

	initial begin
		void'($urandom(54));
		errorCount = 0;
		checkCount = 0;
		rst = 1'b1;
		deviceReadEnabled = '0;
		deviceWriteEnabled = '0;
		for (int j = 0; j < memBusPkg::deviceCount; j++) begin
			deviceAddress[j] = '0;
			deviceDataOut[j] = '0;
		end

		applyReset();
		checkResetState();
		checkRoundRobin(); // The pointer is still at device 0 here.
		fillMemory();
		checkSingleAccess();
		checkReadIsolation();
		runRandomTraffic();

		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule : memorySubsystemTb

/* hw/arbiterInterface.sv */
`timescale 1ns/1ps

interface arbiterInterface;

	logic request;
	logic grant; // Registered, held until the request drops.

	modport device (
		output request,
		input grant
	);

	modport arbiter (
		input request,
		output grant
	);

endinterface : arbiterInterface

/* hw/memBusPkg.sv */
package memBusPkg;

	localparam int addressWidth = 8;
	localparam int dataWidth = 16;
	localparam int deviceCount = 4;

	// Cycles from accepting an access to the completion pulse.
	localparam int ramLatency = 2;
	localparam int ramDepth = 1 << addressWidth;

	localparam int deviceIndexWidth = $clog2(deviceCount);
	localparam int latencyCountWidth = $clog2(ramLatency + 1);

	typedef logic [addressWidth - 1:0] memAddress;
	typedef logic [dataWidth - 1:0] memData;

	// Numbers a device, used for the round-robin pointer.
	typedef logic [deviceIndexWidth - 1:0] deviceIndex;

	// One bit per device.
	typedef logic [deviceCount - 1:0] deviceMask;

	typedef logic [latencyCountWidth - 1:0] latencyCount;

	typedef enum logic [1:0] {
		ramIdle,
		ramBusy,
		ramDone
	} ramState;

endpackage : memBusPkg

/* hw/memoryBus.sv */
`timescale 1ns/1ps

module memoryBus (
	memoryInterface.slave devicePorts [memBusPkg::deviceCount],
	arbiterInterface.device arbiterPorts [memBusPkg::deviceCount],
	memoryInterface.master ramPort
);

	memBusPkg::memAddress address [memBusPkg::deviceCount];
	memBusPkg::memData dataOut [memBusPkg::deviceCount];
	memBusPkg::memData dataIn [memBusPkg::deviceCount];
	memBusPkg::deviceMask readEnabled;
	memBusPkg::deviceMask writeEnabled;
	memBusPkg::deviceMask functionComplete;
	memBusPkg::deviceMask grant;

	memBusPkg::memAddress ramAddress;
	memBusPkg::memData ramDataOut;
	memBusPkg::memData ramDataIn;
	logic ramReadEnabled;
	logic ramWriteEnabled;
	logic ramFunctionComplete;

	genvar i;

	generate
		for (i = 0; i < memBusPkg::deviceCount; i++) begin : gDevices
			// Completion keeps the request up so the grant survives the last cycle.
			assign arbiterPorts[i].request = readEnabled[i] || writeEnabled[i] ||
				functionComplete[i];
			assign grant[i] = arbiterPorts[i].grant;

			assign address[i] = devicePorts[i].address;
			assign dataOut[i] = devicePorts[i].dataOut;
			assign readEnabled[i] = devicePorts[i].readEnabled;
			assign writeEnabled[i] = devicePorts[i].writeEnabled;

			assign devicePorts[i].dataIn = dataIn[i];
			assign devicePorts[i].functionComplete = functionComplete[i];
		end
	endgenerate

	assign ramPort.address = ramAddress;
	assign ramPort.dataOut = ramDataOut;
	assign ramPort.readEnabled = ramReadEnabled;
	assign ramPort.writeEnabled = ramWriteEnabled;
	assign ramDataIn = ramPort.dataIn;
	assign ramFunctionComplete = ramPort.functionComplete;

	always_comb begin
		ramAddress = '0;
		ramDataOut = '0;
		ramReadEnabled = 1'b0;
		ramWriteEnabled = 1'b0;
		for (int j = 0; j < memBusPkg::deviceCount; j++) begin
			if (grant[j]) begin
				ramAddress = address[j];
				ramDataOut = dataOut[j];
				ramReadEnabled = readEnabled[j];
				ramWriteEnabled = writeEnabled[j];
			end
		end
	end

	// Devices without the grant see an idle port.
	always_comb begin
		for (int j = 0; j < memBusPkg::deviceCount; j++) begin
			dataIn[j] = grant[j] ? ramDataIn : '0;
			functionComplete[j] = grant[j] && ramFunctionComplete;
		end
	end

	singleEnable: assert final (!(ramReadEnabled && ramWriteEnabled))
		else $error("Granted device drives read and write enable together.");

endmodule : memoryBus

/* hw/memoryInterface.sv */
`timescale 1ns/1ps

interface memoryInterface;

	memBusPkg::memAddress address;
	memBusPkg::memData dataOut; // Write data, master to slave.
	logic readEnabled;
	logic writeEnabled;

	memBusPkg::memData dataIn; // Read data, valid while functionComplete is high.
	logic functionComplete;

	// The master holds its enable until it has seen the one-cycle completion.
	modport master (
		output address,
		output dataOut,
		output readEnabled,
		output writeEnabled,
		input dataIn,
		input functionComplete
	);

	modport slave (
		input address,
		input dataOut,
		input readEnabled,
		input writeEnabled,
		output dataIn,
		output functionComplete
	);

endinterface : memoryInterface

/* hw/memorySubsystem.sv */
`timescale 1ns/1ps

module memorySubsystem (
	input logic clk,
	input logic rst,
	input memBusPkg::memAddress deviceAddress [memBusPkg::deviceCount],
	input memBusPkg::memData deviceDataOut [memBusPkg::deviceCount],
	input memBusPkg::deviceMask deviceReadEnabled,
	input memBusPkg::deviceMask deviceWriteEnabled,
	output memBusPkg::memData deviceDataIn [memBusPkg::deviceCount],
	output memBusPkg::deviceMask deviceFunctionComplete
);

	// One link per device between the ports and the bus.
	memoryInterface deviceLinks [memBusPkg::deviceCount] ();

	// Bus to RAM.
	memoryInterface ramLink ();

	arbiterInterface arbiterLinks [memBusPkg::deviceCount] ();

	genvar i;

	generate
		for (i = 0; i < memBusPkg::deviceCount; i++) begin : gDevicePorts
			assign deviceLinks[i].address = deviceAddress[i];
			assign deviceLinks[i].dataOut = deviceDataOut[i];
			assign deviceLinks[i].readEnabled = deviceReadEnabled[i];
			assign deviceLinks[i].writeEnabled = deviceWriteEnabled[i];

			assign deviceDataIn[i] = deviceLinks[i].dataIn;
			assign deviceFunctionComplete[i] = deviceLinks[i].functionComplete;
		end
	endgenerate

	roundRobinArbiter arbiter (
		.clk(clk),
		.rst(rst),
		.arbiterPorts(arbiterLinks)
	);

	memoryBus bus (
		.devicePorts(deviceLinks),
		.arbiterPorts(arbiterLinks),
		.ramPort(ramLink)
	);

	sharedRam ram (
		.clk(clk),
		.rst(rst),
		.ramPort(ramLink)
	);

endmodule : memorySubsystem

/* hw/roundRobinArbiter.sv */
`timescale 1ns/1ps

module roundRobinArbiter (
	input logic clk,
	input logic rst,
	arbiterInterface.arbiter arbiterPorts [memBusPkg::deviceCount]
);

	localparam memBusPkg::deviceIndex lastIndex =
		memBusPkg::deviceIndex'(memBusPkg::deviceCount - 1);

	memBusPkg::deviceMask requests;
	memBusPkg::deviceMask grant;
	memBusPkg::deviceMask nextGrant;
	memBusPkg::deviceIndex pointer; // First device to look at on the next search.
	memBusPkg::deviceIndex nextIndex;
	logic found;

	genvar i;

	generate
		for (i = 0; i < memBusPkg::deviceCount; i++) begin : gPorts
			assign requests[i] = arbiterPorts[i].request;
			assign arbiterPorts[i].grant = grant[i];
		end
	endgenerate

	// Search starts at the pointer and wraps around once.
	always_comb begin
		int candidate;

		nextGrant = '0;
		nextIndex = '0;
		found = 1'b0;
		for (int offset = 0; offset < memBusPkg::deviceCount; offset++) begin
			candidate = (int'(pointer) + offset) % memBusPkg::deviceCount;
			if (!found && requests[candidate]) begin
				found = 1'b1;
				nextIndex = memBusPkg::deviceIndex'(candidate);
				nextGrant[candidate] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			grant <= '0;
			pointer <= '0;
		end else if (grant != '0) begin
			if ((grant & requests) == '0) begin
				grant <= '0; // Owner let go, bus is free from the next cycle.
			end
		end else if (found) begin
			grant <= nextGrant;
			if (nextIndex == lastIndex) begin
				pointer <= '0;
			end else begin
				pointer <= memBusPkg::deviceIndex'(nextIndex + 1'b1);
			end
		end
	end

	grantOneHot: assert property (
		@(posedge clk) disable iff (rst) $onehot0(grant)
	) else $error("Arbiter granted more than one device: %b", grant);

	// Every grant, fresh or held, needs a request seen at the previous edge.
	grantFollowsRequest: assert property (
		@(posedge clk) disable iff (rst)
		(grant & ~$past(requests)) == '0
	) else $error("Arbiter granted a device that was not requesting: %b", grant);

endmodule : roundRobinArbiter

/* hw/sharedRam.sv */
`timescale 1ns/1ps

module sharedRam (
	input logic clk,
	input logic rst,
	memoryInterface.slave ramPort
);

	memBusPkg::memData memory [memBusPkg::ramDepth];
	memBusPkg::ramState state;
	memBusPkg::latencyCount busyCount; // Cycles since acceptance.
	memBusPkg::memAddress addressReg;
	memBusPkg::memData readData;
	logic accept;

	assign accept = (state == memBusPkg::ramIdle) &&
		(ramPort.readEnabled || ramPort.writeEnabled);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= memBusPkg::ramIdle;
			busyCount <= '0;
		end else begin
			case (state)
				memBusPkg::ramIdle: begin
					if (accept) begin
						state <= memBusPkg::ramBusy;
						busyCount <= memBusPkg::latencyCount'(1);
					end
				end
				memBusPkg::ramBusy: begin
					if (busyCount == memBusPkg::latencyCount'(memBusPkg::ramLatency - 1)) begin
						state <= memBusPkg::ramDone;
					end else begin
						busyCount <= busyCount + 1'b1;
					end
				end
				// Enables are still up here, so nothing is accepted in this cycle.
				memBusPkg::ramDone: state <= memBusPkg::ramIdle;
				default: state <= memBusPkg::ramIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addressReg <= ramPort.address;
			if (ramPort.writeEnabled) begin
				memory[ramPort.address] <= ramPort.dataOut;
			end
		end
		if (state == memBusPkg::ramBusy) begin
			readData <= memory[addressReg];
		end
	end

	assign ramPort.functionComplete = state == memBusPkg::ramDone;
	assign ramPort.dataIn = (state == memBusPkg::ramDone) ? readData : '0;

	completePulse: assert property (
		@(posedge clk) disable iff (rst)
		ramPort.functionComplete |=> !ramPort.functionComplete
	) else $error("functionComplete held for more than one cycle.");

	// The granted device must hold its access until completion.
	holdDuringBusy: assert property (
		@(posedge clk) disable iff (rst)
		state == memBusPkg::ramBusy |->
			$stable(ramPort.readEnabled) && $stable(ramPort.writeEnabled) &&
			$stable(ramPort.address)
	) else $error("Access changed while the RAM was busy.");

endmodule : sharedRam

/* memorySubsystem.f */
hw/memBusPkg.sv
hw/memoryInterface.sv
hw/arbiterInterface.sv
hw/roundRobinArbiter.sv
hw/memoryBus.sv
hw/sharedRam.sv
hw/memorySubsystem.sv
bench/memorySubsystemTb.sv
